// ==== cache_pkg.sv ====
// cache geometry and controller states, referenced by scoped name from the cache RTL and testbench
`default_nettype none

package cache_pkg;

    // word addressed, 16-bit words
    localparam int word_w     = 16;                      // data and address width
    localparam int offset_w   = 2;                       // word within line
    localparam int index_w    = 4;                       // set select
    localparam int tag_w      = word_w - index_w - offset_w; // 10 bits left over

    localparam int line_words = 1 << offset_w;           // 4 words per line
    localparam int num_sets   = 1 << index_w;            // 16 sets, direct mapped

    // controller FSM
    // st_idle      lookup, hit served combinationally
    // st_arb_wait  request held until the arbiter grants
    // st_fill      one line word in flight
    // st_write_mem write-through access in flight
    typedef enum logic [1:0] {
        st_idle,
        st_arb_wait,
        st_fill,
        st_write_mem
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
// main memory timing and depth plus arbiter ownership, shared by the memory-side RTL and testbench
`default_nettype none

package mem_pkg;

    localparam int mem_latency = 4;                      // capture to data_valid, cycles
    localparam int mem_words   = 65536;                  // full 16-bit word space
    localparam int lat_w       = $clog2(mem_latency + 1); // latency counter width

    // who holds the memory port
    typedef enum logic [1:0] {
        own_none,
        own_icache,
        own_dcache
    } owner_t;

endpackage

`default_nettype wire

// ==== cache_array.sv ====
// direct-mapped tag, valid and data store; lookup is combinational, writes come from one controller
`timescale 1ns/100ps
`default_nettype none

module cache_array (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cache_pkg::word_w-1:0]    addr,        // lookup address
    input  logic                            word_we,     // hit write, one word
    input  logic [cache_pkg::word_w-1:0]    word_wdata,
    input  logic                            fill_we,     // line fill, one word per beat
    input  logic [cache_pkg::offset_w-1:0]  fill_offset,
    input  logic [cache_pkg::word_w-1:0]    fill_wdata,
    input  logic                            fill_last,   // last beat sets tag and valid
    output logic                            hit,
    output logic [cache_pkg::word_w-1:0]    rdata
);

    logic [cache_pkg::word_w-1:0]   data_mem [cache_pkg::num_sets][cache_pkg::line_words];
    logic [cache_pkg::tag_w-1:0]    tag_mem  [cache_pkg::num_sets];
    logic [cache_pkg::num_sets-1:0] valid;

    logic [cache_pkg::tag_w-1:0]    tag;
    logic [cache_pkg::index_w-1:0]  index;
    logic [cache_pkg::offset_w-1:0] offset;

    // address split: tag | index | offset
    assign offset = addr[cache_pkg::offset_w-1:0];
    assign index  = addr[cache_pkg::offset_w +: cache_pkg::index_w];
    assign tag    = addr[cache_pkg::word_w-1 -: cache_pkg::tag_w];

    assign hit   = valid[index] && (tag_mem[index] == tag);
    assign rdata = data_mem[index][offset];  // meaningful only on hit

    // valid bits, all sets empty out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill_we && fill_last) begin
            valid[index] <= 1'b1;
        end
    end

    // data and tag storage
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[index][fill_offset] <= fill_wdata;
            if (fill_last) begin
                tag_mem[index] <= tag;           // line now owned by this tag
            end
        end else if (word_we) begin
            data_mem[index][offset] <= word_wdata; // write hit, other words untouched
        end
    end

endmodule

`default_nettype wire

// ==== cache_controller.sv ====
// per-cache FSM: hit detect, four-beat line fill on read miss, write-through when has_write is set
`timescale 1ns/100ps
`default_nettype none

module cache_controller #(
    parameter bit has_write = 1'b1                   // 0 for the instruction cache
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // processor side
    input  logic [cache_pkg::word_w-1:0]    addr,
    input  logic                            rd_req,
    input  logic                            wr_req,
    input  logic [cache_pkg::word_w-1:0]    data_in,
    output logic [cache_pkg::word_w-1:0]    data_out,
    output logic                            stall,
    // cache array
    input  logic                            lookup_hit,
    input  logic [cache_pkg::word_w-1:0]    lookup_data,
    output logic                            arr_word_we,
    output logic                            arr_fill_we,
    output logic                            arr_fill_last,
    output logic [cache_pkg::offset_w-1:0]  arr_fill_offset,
    output logic [cache_pkg::word_w-1:0]    arr_fill_data,
    // arbiter
    output logic                            mem_req,
    output logic                            mem_wr,
    output logic [cache_pkg::word_w-1:0]    mem_addr,
    output logic [cache_pkg::word_w-1:0]    mem_wdata,
    input  logic                            mem_grant,
    input  logic                            mem_valid,
    input  logic [cache_pkg::word_w-1:0]    mem_rdata
);

    cache_pkg::ctrl_state_t         state, state_nxt;
    logic [cache_pkg::offset_w-1:0] fill_cnt;        // next line word to fetch
    logic                           wr_done;         // write acked, ready for one cycle
    logic                           wr_pend;
    logic [cache_pkg::word_w-1:0]   wr_data;
    logic                           idle, rd_hit;

    // write path exists only in the data cache
    if (has_write) begin : g_wr
        assign wr_pend = wr_req;
        assign wr_data = data_in;
    end else begin : g_no_wr
        assign wr_pend = 1'b0;
        assign wr_data = '0;
    end

    assign idle   = (state == cache_pkg::st_idle);
    assign rd_hit = idle && rd_req && lookup_hit;

    // ready = ~stall, read hits and finished writes pass in st_idle
    assign stall    = (rd_req || wr_pend) && !(rd_hit || (idle && wr_done));
    assign data_out = lookup_data;

    // memory side, req low in st_idle gives the gap between fill beats
    assign mem_req   = !idle;
    assign mem_wr    = mem_req && wr_pend;
    assign mem_addr  = wr_pend ? addr : {addr[cache_pkg::word_w-1:cache_pkg::offset_w], fill_cnt};
    assign mem_wdata = wr_data;

    // array writes
    assign arr_fill_we     = (state == cache_pkg::st_fill) && mem_valid;
    assign arr_fill_offset = fill_cnt;
    assign arr_fill_data   = mem_rdata;
    assign arr_fill_last   = (fill_cnt == cache_pkg::offset_w'(cache_pkg::line_words - 1));
    assign arr_word_we     = idle && wr_done && lookup_hit; // no write-allocate

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::st_idle: begin
                if ((wr_pend && !wr_done) || (rd_req && !lookup_hit && !wr_pend)) begin
                    state_nxt = cache_pkg::st_arb_wait;
                end
            end
            cache_pkg::st_arb_wait: begin
                if (mem_grant) begin                 // memory captures this cycle
                    state_nxt = wr_pend ? cache_pkg::st_write_mem : cache_pkg::st_fill;
                end
            end
            default: begin                           // fill or write in flight
                if (mem_valid) begin
                    state_nxt = cache_pkg::st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cache_pkg::st_idle;
            fill_cnt <= '0;
            wr_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (arr_fill_we) begin
                fill_cnt <= fill_cnt + 1'b1;         // wraps to 0 after the last beat
            end
            if ((state == cache_pkg::st_write_mem) && mem_valid) begin
                wr_done <= 1'b1;
            end else if (idle) begin
                wr_done <= 1'b0;                     // ready held a single cycle
            end
        end
    end

endmodule

`default_nettype wire

// ==== memory_arbitration.sv ====
// shares the single memory port between icache and dcache, round-robin, held until the owner lets go
`timescale 1ns/100ps
`default_nettype none

module memory_arbitration (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         icache_req,
    input  logic                         icache_wr,
    input  logic [cache_pkg::word_w-1:0] icache_addr,
    input  logic [cache_pkg::word_w-1:0] icache_wdata,
    output logic                         icache_grant,
    output logic                         icache_valid,
    input  logic                         dcache_req,
    input  logic                         dcache_wr,
    input  logic [cache_pkg::word_w-1:0] dcache_addr,
    input  logic [cache_pkg::word_w-1:0] dcache_wdata,
    output logic                         dcache_grant,
    output logic                         dcache_valid,
    output logic                         mem_enable,
    output logic                         mem_wr,
    output logic [cache_pkg::word_w-1:0] mem_addr,
    output logic [cache_pkg::word_w-1:0] mem_wdata,
    input  logic                         mem_valid
);

    mem_pkg::owner_t owner, last_owner, pick;
    logic            owner_req;

    assign icache_grant = (owner == mem_pkg::own_icache);
    assign dcache_grant = (owner == mem_pkg::own_dcache);
    assign owner_req    = (icache_grant && icache_req) || (dcache_grant && dcache_req);

    // candidate when the port is free, tie goes to the side not served last
    always_comb begin
        if (icache_req && dcache_req) begin
            pick = (last_owner == mem_pkg::own_icache) ? mem_pkg::own_dcache : mem_pkg::own_icache;
        end else if (icache_req) begin
            pick = mem_pkg::own_icache;
        end else if (dcache_req) begin
            pick = mem_pkg::own_dcache;
        end else begin
            pick = mem_pkg::own_none;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner      <= mem_pkg::own_none;
            last_owner <= mem_pkg::own_none;
        end else if (owner == mem_pkg::own_none) begin
            owner <= pick;
            if (pick != mem_pkg::own_none) begin
                last_owner <= pick;
            end
        end else if (!owner_req) begin
            owner <= mem_pkg::own_none;          // released, one free cycle between owners
        end
    end

    // memory port steering
    assign mem_enable = owner_req;
    always_comb begin
        mem_wr    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        if (icache_grant) begin
            mem_wr    = icache_wr;
            mem_addr  = icache_addr;
            mem_wdata = icache_wdata;
        end else if (dcache_grant) begin
            mem_wr    = dcache_wr;
            mem_addr  = dcache_addr;
            mem_wdata = dcache_wdata;
        end
    end

    // ack goes back only to the side that owns the port
    assign icache_valid = icache_grant && mem_valid;
    assign dcache_valid = dcache_grant && mem_valid;

endmodule

`default_nettype wire

// ==== memory4c.sv ====
// fixed-latency main memory model; one access at a time, each acked by a single data_valid pulse
`timescale 1ns/100ps
`default_nettype none

module memory4c (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic                         wr,
    input  logic [cache_pkg::word_w-1:0] addr,
    input  logic [cache_pkg::word_w-1:0] data_in,
    output logic [cache_pkg::word_w-1:0] data_out,
    output logic                         data_valid
);

    logic [cache_pkg::word_w-1:0] mem [mem_pkg::mem_words];
    logic [cache_pkg::word_w-1:0] addr_q, data_q;      // captured access
    logic                         wr_q;
    logic                         enable_q, busy;
    logic [mem_pkg::lat_w-1:0]    cnt;                 // cycles left
    logic                         start, fire;

    assign start = !busy && enable && !enable_q;       // new access on enable rise
    assign fire  = busy && (cnt <= 1);                 // last latency cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q   <= 1'b0;
            busy       <= 1'b0;
            cnt        <= '0;
            data_valid <= 1'b0;
        end else begin
            enable_q   <= enable;
            data_valid <= fire;                        // one-cycle pulse
            if (start) begin
                busy <= 1'b1;
                cnt  <= mem_pkg::lat_w'(mem_pkg::mem_latency - 1);
            end else if (fire) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
            data_q <= data_in;
            wr_q   <= wr;
        end
    end

    // storage, cleared at reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::mem_words; i++) begin
                mem[i] <= '0;
            end
            data_out <= '0;
        end else if (fire) begin
            if (wr_q) begin
                mem[addr_q] <= data_q;
            end else begin
                data_out <= mem[addr_q];           // held until the next read
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_container.sv ====
// top of the memory subsystem: both caches, their controllers, the port arbiter and main memory
`timescale 1ns/100ps
`default_nettype none

module cache_container (
    input  logic                         clk,
    input  logic                         rst_n,
    // data side
    input  logic [cache_pkg::word_w-1:0] maddr,
    input  logic [cache_pkg::word_w-1:0] mdata_in,
    input  logic                         mren,
    input  logic                         mwen,
    output logic [cache_pkg::word_w-1:0] mdata_out,
    output logic                         mdata_ready,
    // instruction side
    input  logic [cache_pkg::word_w-1:0] iaddr,
    input  logic                         iren,
    output logic [cache_pkg::word_w-1:0] idata,
    output logic                         idata_ready
);

    // dcache wires
    logic                           d_stall, d_hit, d_word_we, d_fill_we, d_fill_last;
    logic [cache_pkg::offset_w-1:0] d_fill_offset;
    logic [cache_pkg::word_w-1:0]   d_rdata, d_fill_data, d_mem_addr, d_mem_wdata;
    logic                           d_mem_req, d_mem_wr, d_grant, d_valid;
    // icache wires
    logic                           i_stall, i_hit, i_word_we, i_fill_we, i_fill_last;
    logic [cache_pkg::offset_w-1:0] i_fill_offset;
    logic [cache_pkg::word_w-1:0]   i_rdata, i_fill_data, i_mem_addr, i_mem_wdata;
    logic                           i_mem_req, i_mem_wr, i_grant, i_valid;
    // memory port
    logic                           mem_enable, mem_wr, mem_valid;
    logic [cache_pkg::word_w-1:0]   mem_addr, mem_wdata, mem_rdata;

    assign mdata_ready = ~d_stall;
    assign idata_ready = ~i_stall;

    cache_array dcache_array (
        .clk(clk), .rst_n(rst_n), .addr(maddr),
        .word_we(d_word_we), .word_wdata(mdata_in),
        .fill_we(d_fill_we), .fill_offset(d_fill_offset),
        .fill_wdata(d_fill_data), .fill_last(d_fill_last),
        .hit(d_hit), .rdata(d_rdata)
    );

    cache_controller #(.has_write(1'b1)) dcache_ctrl (
        .clk(clk), .rst_n(rst_n),
        .addr(maddr), .rd_req(mren), .wr_req(mwen), .data_in(mdata_in),
        .data_out(mdata_out), .stall(d_stall),
        .lookup_hit(d_hit), .lookup_data(d_rdata),
        .arr_word_we(d_word_we), .arr_fill_we(d_fill_we), .arr_fill_last(d_fill_last),
        .arr_fill_offset(d_fill_offset), .arr_fill_data(d_fill_data),
        .mem_req(d_mem_req), .mem_wr(d_mem_wr), .mem_addr(d_mem_addr),
        .mem_wdata(d_mem_wdata), .mem_grant(d_grant), .mem_valid(d_valid),
        .mem_rdata(mem_rdata)
    );

    cache_array icache_array (
        .clk(clk), .rst_n(rst_n), .addr(iaddr),
        .word_we(i_word_we), .word_wdata('0),      // read-only, never written on hit
        .fill_we(i_fill_we), .fill_offset(i_fill_offset),
        .fill_wdata(i_fill_data), .fill_last(i_fill_last),
        .hit(i_hit), .rdata(i_rdata)
    );

    // write path not built, write inputs left open
    cache_controller #(.has_write(1'b0)) icache_ctrl (
        .clk(clk), .rst_n(rst_n),
        .addr(iaddr), .rd_req(iren), .wr_req(), .data_in(),
        .data_out(idata), .stall(i_stall),
        .lookup_hit(i_hit), .lookup_data(i_rdata),
        .arr_word_we(i_word_we), .arr_fill_we(i_fill_we), .arr_fill_last(i_fill_last),
        .arr_fill_offset(i_fill_offset), .arr_fill_data(i_fill_data),
        .mem_req(i_mem_req), .mem_wr(i_mem_wr), .mem_addr(i_mem_addr),
        .mem_wdata(i_mem_wdata), .mem_grant(i_grant), .mem_valid(i_valid),
        .mem_rdata(mem_rdata)
    );

    memory_arbitration mem_arb (
        .clk(clk), .rst_n(rst_n),
        .icache_req(i_mem_req), .icache_wr(i_mem_wr),
        .icache_addr(i_mem_addr), .icache_wdata(i_mem_wdata),
        .icache_grant(i_grant), .icache_valid(i_valid),
        .dcache_req(d_mem_req), .dcache_wr(d_mem_wr),
        .dcache_addr(d_mem_addr), .dcache_wdata(d_mem_wdata),
        .dcache_grant(d_grant), .dcache_valid(d_valid),
        .mem_enable(mem_enable), .mem_wr(mem_wr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_valid(mem_valid)
    );

    memory4c main_mem (
        .clk(clk), .rst_n(rst_n),
        .enable(mem_enable), .wr(mem_wr), .addr(mem_addr), .data_in(mem_wdata),
        .data_out(mem_rdata), .data_valid(mem_valid)
    );

endmodule

`default_nettype wire

// ==== tb_cache_container.sv ====
// directed testbench for the cache subsystem; checks both caches against a write-through shadow memory
`timescale 1ns/100ps
`default_nettype none

module tb_cache_container;

    localparam int num_ops     = 83;                   // processor accesses over all tests
    // four beats each possibly behind a beat of the other cache
    localparam int miss_worst  = 2 * cache_pkg::line_words * (mem_pkg::mem_latency + 4);
    localparam int cycle_limit = num_ops * miss_worst + 200;

    logic                         clk;
    logic                         rst_n;
    logic [cache_pkg::word_w-1:0] maddr, mdata_in, mdata_out;
    logic                         mren, mwen, mdata_ready;
    logic [cache_pkg::word_w-1:0] iaddr, idata;
    logic                         iren, idata_ready;

    logic [cache_pkg::word_w-1:0] shadow [mem_pkg::mem_words]; // expected memory contents
    logic [31:0]                  lfsr;
    int                           cycles = 0;
    int                           checks = 0;
    int                           word_errs = 0;
    int                           bit_errs = 0;

    cache_container cache_container_i (
        .clk(clk), .rst_n(rst_n),
        .maddr(maddr), .mdata_in(mdata_in), .mren(mren), .mwen(mwen),
        .mdata_out(mdata_out), .mdata_ready(mdata_ready),
        .iaddr(iaddr), .iren(iren), .idata(idata), .idata_ready(idata_ready)
    );

    always #10 clk = ~clk;                              // 20 ns period

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a request never completed", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [cache_pkg::word_w-1:0] rand_bits(input int n);
        logic [cache_pkg::word_w-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[cache_pkg::word_w-2:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_word(input string name, input logic [cache_pkg::word_w-1:0] exp,
                              input logic [cache_pkg::word_w-1:0] act);
        checks++;
        if (act !== exp) begin
            word_errs++;
            $display("CHECK FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            bit_errs++;
            $display("CHECK FAILED %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    // memory always takes the value under write-through
    task automatic data_write(input logic [cache_pkg::word_w-1:0] a,
                              input logic [cache_pkg::word_w-1:0] d);
        @(posedge clk);
        maddr    <= a;
        mdata_in <= d;
        mwen     <= 1'b1;
        @(negedge clk);
        while (!mdata_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        mwen      <= 1'b0;                              // completes on this edge
        shadow[a] = d;
    endtask

    task automatic data_read_check(input logic [cache_pkg::word_w-1:0] a);
        @(posedge clk);
        maddr <= a;
        mren  <= 1'b1;
        @(negedge clk);
        while (!mdata_ready) begin
            @(negedge clk);
        end
        check_word("mdata_out", shadow[a], mdata_out); // stable mid-cycle
        @(posedge clk);
        mren <= 1'b0;
    endtask

    task automatic inst_fetch_check(input logic [cache_pkg::word_w-1:0] a);
        @(posedge clk);
        iaddr <= a;
        iren  <= 1'b1;
        @(negedge clk);
        while (!idata_ready) begin
            @(negedge clk);
        end
        check_word("idata", shadow[a], idata);
        @(posedge clk);
        iren <= 1'b0;
    endtask

    task automatic data_op(input logic is_wr, input logic [cache_pkg::word_w-1:0] a,
                           input logic [cache_pkg::word_w-1:0] d);
        if (is_wr) begin
            data_write(a, d);
        end else begin
            data_read_check(a);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_bit("mdata_ready", 1'b1, mdata_ready);
        check_bit("idata_ready", 1'b1, idata_ready);
        data_read_check(16'h0040);                      // never written so memory still holds zero
    endtask

    task automatic test_write_read();
        data_write(16'h0100, rand_bits(16));            // write miss updates memory only
        data_read_check(16'h0100);                      // miss fills the line
        data_read_check(16'h0102);                      // hit in the new line
    endtask

    task automatic test_line_evict();
        for (int k = 0; k < 4; k++) begin
            data_write(16'h0120 + 16'(k), rand_bits(16));
        end
        for (int k = 0; k < 4; k++) begin
            data_read_check(16'h0120 + 16'(k));         // one fill then three hits
        end
        data_write(16'h0121, rand_bits(16));            // write hit updates array and memory
        data_read_check(16'h0121);
        data_write(16'h0521, rand_bits(16));            // same index with another tag
        data_read_check(16'h0521);                      // evicts 0x012x
        data_read_check(16'h0120);                      // and refills it
        data_read_check(16'h0523);
    endtask

    // icache has never held the 0x010x line
    task automatic test_fetch_after_write();
        inst_fetch_check(16'h0100);
    endtask

    task automatic test_dual_miss();
        data_write(16'h0301, rand_bits(16));
        data_write(16'h0203, rand_bits(16));
        fork
            data_read_check(16'h0301);
            inst_fetch_check(16'h0203);
        join
    endtask

    // data window 0x0800..0x083f with fetches from lines never written again
    task automatic test_random_mix();
        logic [cache_pkg::word_w-1:0] a, d, ia;
        logic                         is_wr;
        for (int n = 0; n < 40; n++) begin
            is_wr = (rand_bits(1) == 16'd1);
            a     = 16'h0800 + rand_bits(6);
            d     = rand_bits(16);
            ia    = 16'h0100 + (rand_bits(2) << 8) + rand_bits(2);
            if (n % 2 == 1) begin
                fork
                    data_op(is_wr, a, d);
                    inst_fetch_check(ia);
                join
            end else begin
                data_op(is_wr, a, d);
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        lfsr     = 32'h1192;
        rst_n    <= 1'b0;
        maddr    <= '0;
        mdata_in <= '0;
        mren     <= 1'b0;
        mwen     <= 1'b0;
        iaddr    <= '0;
        iren     <= 1'b0;
        for (int k = 0; k < mem_pkg::mem_words; k++) begin
            shadow[k] = '0;                             // memory clears at reset
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_write_read();
        test_line_evict();
        test_fetch_after_write();
        test_dual_miss();
        test_random_mix();

        $display("checks %0d, word errors %0d, bit errors %0d", checks, word_errs, bit_errs);
        if (word_errs + bit_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
cache_pkg.sv
mem_pkg.sv
cache_array.sv
cache_controller.sv
memory_arbitration.sv
memory4c.sv
cache_container.sv
tb_cache_container.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -f build.f --top-module tb_cache_container &&
./obj_dir/Vtb_cache_container > sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
